//--- verilog/rename_macros.svh
// sizing constants for the rename front, included by the RTL, the package and the testbench
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// architectural register file size
`define ARCH_REGS 32

// reorder buffer entries, tags run 1..ROB_SZ
// tag 0 is reserved for "value in register file"
`define ROB_SZ 8

// hard-wired zero register, never renamed
`define ZERO_REG 0

`endif

//--- verilog/rename_pkg.sv
// shared types and the circular tag window test, imported by the rename RTL and testbench
`default_nettype none

`include "rename_macros.svh"

package rename_pkg;

    typedef logic [$clog2(`ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(`ROB_SZ + 1)-1:0] rob_tag_t;

    // true when tag lies circularly in (after, upto], never for tag 0
    function automatic logic tag_in_window(input rob_tag_t tag, input rob_tag_t after,
                                           input rob_tag_t upto);
        logic in_window;
        if (after <= upto) begin
            in_window = (tag > after) && (tag <= upto);
        end else begin
            // window wraps past the last slot
            in_window = (tag > after) || (tag <= upto);
        end
        return in_window && (tag != '0);
    endfunction

endpackage

`default_nettype wire

//--- verilog/map_table.sv
// rename map: newest ROB tag and t_plus per architectural register, with source lookups
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module map_table (
    input  wire logic                clock,
    input  wire logic                reset,

    // dispatch
    input  wire logic                alloc_valid,
    input  rename_pkg::rob_tag_t     alloc_tag,
    input  wire logic                has_dest,
    input  rename_pkg::arch_reg_t    dest_reg,
    input  rename_pkg::arch_reg_t    rs1_idx,
    input  wire logic                rs1_valid,
    input  rename_pkg::arch_reg_t    rs2_idx,
    input  wire logic                rs2_valid,

    // common data bus
    input  wire logic                cdb_valid,
    input  rename_pkg::rob_tag_t     cdb_tag,

    // retire from the ROB head
    input  wire logic                retire_valid,
    input  rename_pkg::rob_tag_t     retire_tag,

    // branch squash
    input  wire logic                branch_valid,
    input  rename_pkg::rob_tag_t     branch_tag,
    input  rename_pkg::rob_tag_t     tail_tag,

    // source operand lookups
    output rename_pkg::rob_tag_t     rs1_tag,
    output logic                     rs1_ready,
    output rename_pkg::rob_tag_t     rs2_tag,
    output logic                     rs2_ready
);

    import rename_pkg::*;

    localparam arch_reg_t ZERO_IDX = arch_reg_t'(`ZERO_REG);

    // one tag and one t_plus bit per architectural register
    rob_tag_t               tag_q [`ARCH_REGS];
    logic [`ARCH_REGS-1:0]  t_plus_q;

    // entries whose writer is younger than the squashing branch
    logic [`ARCH_REGS-1:0]  squash_hit;

    logic                   write_dest;

    // x0 is never renamed, instructions without dest only take a ROB slot
    assign write_dest = alloc_valid && has_dest && (dest_reg != ZERO_IDX);

    always_comb begin
        for (int i = 0; i < `ARCH_REGS; i++) begin
            squash_hit[i] = branch_valid && tag_in_window(tag_q[i], branch_tag, tail_tag);
        end
    end

    // priority per entry: squash, dispatch, retire, cdb
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                tag_q[i] <= '0;
            end
            t_plus_q <= '0;
        end else begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                if (squash_hit[i]) begin
                    // no recovery of older mapping, fall back to regfile
                    tag_q[i]    <= '0;
                    t_plus_q[i] <= 1'b0;
                end else if (write_dest && dest_reg == arch_reg_t'(i)) begin
                    tag_q[i]    <= alloc_tag;
                    t_plus_q[i] <= 1'b0;
                end else if (retire_valid && tag_q[i] == retire_tag) begin
                    // only if no newer writer replaced the mapping
                    tag_q[i]    <= '0;
                    t_plus_q[i] <= 1'b0;
                end else if (cdb_valid && tag_q[i] != '0 && tag_q[i] == cdb_tag) begin
                    // result now sits in the ROB
                    t_plus_q[i] <= 1'b1;
                end
            end
        end
    end

    // lookups see state before the edge, invalid sources read as tag 0
    assign rs1_tag   = rs1_valid ? tag_q[rs1_idx]    : '0;
    assign rs1_ready = rs1_valid ? t_plus_q[rs1_idx] : 1'b0;
    assign rs2_tag   = rs2_valid ? tag_q[rs2_idx]    : '0;
    assign rs2_ready = rs2_valid ? t_plus_q[rs2_idx] : 1'b0;

endmodule

`default_nettype wire

//--- verilog/reorder_buffer.sv
// circular reorder buffer: tag allocation, completion from the CDB, in-order retire, squash
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module reorder_buffer (
    input  wire logic                clock,
    input  wire logic                reset,

    // dispatch request
    input  wire logic                dispatch_valid,
    input  rename_pkg::arch_reg_t    dest_reg,

    // common data bus
    input  wire logic                cdb_valid,
    input  rename_pkg::rob_tag_t     cdb_tag,

    // branch squash, branch_tag is in flight
    input  wire logic                branch_valid,
    input  rename_pkg::rob_tag_t     branch_tag,

    // allocation towards the map table
    output logic                     alloc_valid,
    output rename_pkg::rob_tag_t     alloc_tag,
    output rename_pkg::rob_tag_t     tail_tag,
    output logic                     rob_full,

    // retire of the head entry
    output logic                     retire_valid,
    output rename_pkg::rob_tag_t     retire_tag,
    output rename_pkg::arch_reg_t    retire_dest
);

    import rename_pkg::*;

    localparam int CNT_W = $bits(rob_tag_t);
    localparam rob_tag_t LAST_TAG = rob_tag_t'(`ROB_SZ);
    localparam rob_tag_t FIRST_TAG = rob_tag_t'(1);
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(`ROB_SZ);

    // head is oldest entry, tail is next free slot
    rob_tag_t           head_q;
    rob_tag_t           tail_q;
    logic [CNT_W-1:0]   count_q;
    logic [CNT_W-1:0]   count_next;
    logic [CNT_W-1:0]   squash_count;

    // slot k holds tag k
    logic [`ROB_SZ:1]   busy_q;
    logic [`ROB_SZ:1]   complete_q;
    arch_reg_t          dest_q [1:`ROB_SZ];

    function automatic rob_tag_t next_tag(input rob_tag_t t);
        return (t == LAST_TAG) ? FIRST_TAG : t + 1'b1;
    endfunction

    function automatic rob_tag_t prev_tag(input rob_tag_t t);
        return (t == FIRST_TAG) ? LAST_TAG : t - 1'b1;
    endfunction

    assign rob_full    = (count_q == FULL_COUNT);
    assign alloc_valid = dispatch_valid && !rob_full && !branch_valid;
    assign alloc_tag   = tail_q;
    // newest allocated entry
    assign tail_tag    = prev_tag(tail_q);

    assign retire_valid = busy_q[head_q] && complete_q[head_q];
    assign retire_tag   = head_q;
    assign retire_dest  = dest_q[head_q];

    // entries kept on a squash: head up to and including the branch
    assign squash_count = (branch_tag >= head_q) ? branch_tag - head_q + 1'b1
                                                 : branch_tag + LAST_TAG - head_q + 1'b1;

    always_comb begin
        if (branch_valid) begin
            count_next = squash_count - retire_valid;
        end else begin
            count_next = count_q + alloc_valid - retire_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head_q     <= FIRST_TAG;
            tail_q     <= FIRST_TAG;
            count_q    <= '0;
            busy_q     <= '0;
            complete_q <= '0;
        end else begin
            for (int k = 1; k <= `ROB_SZ; k++) begin
                if (branch_valid && tag_in_window(rob_tag_t'(k), branch_tag, tail_tag)) begin
                    // younger than the branch, free the slot
                    busy_q[k]     <= 1'b0;
                    complete_q[k] <= 1'b0;
                end else if (retire_valid && head_q == rob_tag_t'(k)) begin
                    busy_q[k]     <= 1'b0;
                    complete_q[k] <= 1'b0;
                end else if (alloc_valid && tail_q == rob_tag_t'(k)) begin
                    busy_q[k]     <= 1'b1;
                    complete_q[k] <= 1'b0;
                end else if (cdb_valid && busy_q[k] && cdb_tag == rob_tag_t'(k)) begin
                    complete_q[k] <= 1'b1;
                end
            end

            if (retire_valid) begin
                head_q <= next_tag(head_q);
            end

            // branch becomes the newest entry
            if (branch_valid) begin
                tail_q <= next_tag(branch_tag);
            end else if (alloc_valid) begin
                tail_q <= next_tag(tail_q);
            end

            count_q <= count_next;
        end
    end

    // destination payload
    always_ff @(posedge clock) begin
        if (alloc_valid) begin
            dest_q[tail_q] <= dest_reg;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rename_core.sv
// top level of the rename front: ROB and map table wired to the dispatch, CDB and squash strobes
`timescale 1ns/1ns
`default_nettype none

module rename_core (
    input  wire logic                clock,
    input  wire logic                reset,

    // dispatch
    input  wire logic                dispatch_valid,
    input  wire logic                has_dest,
    input  rename_pkg::arch_reg_t    dest_reg,
    input  rename_pkg::arch_reg_t    rs1_idx,
    input  wire logic                rs1_valid,
    input  rename_pkg::arch_reg_t    rs2_idx,
    input  wire logic                rs2_valid,

    // common data bus
    input  wire logic                cdb_valid,
    input  rename_pkg::rob_tag_t     cdb_tag,

    // branch squash
    input  wire logic                branch_valid,
    input  rename_pkg::rob_tag_t     branch_tag,

    // renamed sources
    output rename_pkg::rob_tag_t     rs1_tag,
    output logic                     rs1_ready,
    output rename_pkg::rob_tag_t     rs2_tag,
    output logic                     rs2_ready,

    // allocation and retire status
    output rename_pkg::rob_tag_t     alloc_tag,
    output logic                     rob_full,
    output logic                     retire_valid,
    output rename_pkg::rob_tag_t     retire_tag,
    output rename_pkg::arch_reg_t    retire_dest
);

    import rename_pkg::*;

    logic       alloc_valid;
    rob_tag_t   tail_tag;

    reorder_buffer reorder_buffer_inst (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dest_reg       (dest_reg),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .branch_valid   (branch_valid),
        .branch_tag     (branch_tag),
        .alloc_valid    (alloc_valid),
        .alloc_tag      (alloc_tag),
        .tail_tag       (tail_tag),
        .rob_full       (rob_full),
        .retire_valid   (retire_valid),
        .retire_tag     (retire_tag),
        .retire_dest    (retire_dest)
    );

    map_table map_table_inst (
        .clock          (clock),
        .reset          (reset),
        .alloc_valid    (alloc_valid),
        .alloc_tag      (alloc_tag),
        .has_dest       (has_dest),
        .dest_reg       (dest_reg),
        .rs1_idx        (rs1_idx),
        .rs1_valid      (rs1_valid),
        .rs2_idx        (rs2_idx),
        .rs2_valid      (rs2_valid),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .retire_valid   (retire_valid),
        .retire_tag     (retire_tag),
        .branch_valid   (branch_valid),
        .branch_tag     (branch_tag),
        .tail_tag       (tail_tag),
        .rs1_tag        (rs1_tag),
        .rs1_ready      (rs1_ready),
        .rs2_tag        (rs2_tag),
        .rs2_ready      (rs2_ready)
    );

endmodule

`default_nettype wire

//--- sim/rename_asserts.sv
// concurrent checks on the rename front, bound into the top level by the testbench
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module rename_asserts (
    input  wire logic              clock,
    input  wire logic              reset,
    input  wire logic              retire_valid,
    // ROB entry count, same width as a tag
    input  rename_pkg::rob_tag_t   rob_count,
    input  rename_pkg::rob_tag_t   alloc_tag,
    input  wire logic              rs1_valid,
    input  rename_pkg::rob_tag_t   rs1_tag
);

    import rename_pkg::*;

    no_retire_when_empty: assert property (@(posedge clock) disable iff (reset)
        retire_valid |-> rob_count != '0)
        else $error("retire_valid high while the ROB is empty");

    alloc_tag_in_range: assert property (@(posedge clock) disable iff (reset)
        alloc_tag >= rob_tag_t'(1) && alloc_tag <= rob_tag_t'(`ROB_SZ))
        else $error("alloc_tag outside 1..ROB_SZ");

    // invalid source has no producer
    rs1_invalid_reads_zero: assert property (@(posedge clock) disable iff (reset)
        !rs1_valid |-> rs1_tag == '0)
        else $error("rs1_tag nonzero while rs1_valid is low");

endmodule

`default_nettype wire

//--- sim/rename_tb.sv
// directed testbench for the rename front, compares the DUT with a reference model each cycle
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module rename_tb;

    import rename_pkg::*;

    // tests take about 120 cycles, the rest is margin
    localparam int MAX_CYCLES = 400;

    logic       clock;
    logic       reset;
    logic       dispatch_valid;
    logic       has_dest;
    arch_reg_t  dest_reg;
    arch_reg_t  rs1_idx;
    logic       rs1_valid;
    arch_reg_t  rs2_idx;
    logic       rs2_valid;
    logic       cdb_valid;
    rob_tag_t   cdb_tag;
    logic       branch_valid;
    rob_tag_t   branch_tag;
    rob_tag_t   rs1_tag;
    logic       rs1_ready;
    rob_tag_t   rs2_tag;
    logic       rs2_ready;
    rob_tag_t   alloc_tag;
    logic       rob_full;
    logic       retire_valid;
    rob_tag_t   retire_tag;
    arch_reg_t  retire_dest;

    int cycle_count = 0;
    int error_count = 0;

    // reference model of the map and the ROB
    int map_tag [`ARCH_REGS];
    bit map_tplus [`ARCH_REGS];
    int rob_head;
    int rob_tail;
    int rob_count;
    bit rob_busy [1:`ROB_SZ];
    bit rob_done [1:`ROB_SZ];
    int rob_dest [1:`ROB_SZ];

    rename_core rename_core_inst (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .has_dest       (has_dest),
        .dest_reg       (dest_reg),
        .rs1_idx        (rs1_idx),
        .rs1_valid      (rs1_valid),
        .rs2_idx        (rs2_idx),
        .rs2_valid      (rs2_valid),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .branch_valid   (branch_valid),
        .branch_tag     (branch_tag),
        .rs1_tag        (rs1_tag),
        .rs1_ready      (rs1_ready),
        .rs2_tag        (rs2_tag),
        .rs2_ready      (rs2_ready),
        .alloc_tag      (alloc_tag),
        .rob_full       (rob_full),
        .retire_valid   (retire_valid),
        .retire_tag     (retire_tag),
        .retire_dest    (retire_dest)
    );

    bind rename_core rename_asserts rename_asserts_inst (
        .clock          (clock),
        .reset          (reset),
        .retire_valid   (retire_valid),
        .rob_count      (reorder_buffer_inst.count_q),
        .alloc_tag      (alloc_tag),
        .rs1_valid      (rs1_valid),
        .rs1_tag        (rs1_tag)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    function automatic int next_slot(input int t);
        return (t == `ROB_SZ) ? 1 : t + 1;
    endfunction

    // walk forward from the branch towards the newest entry
    function automatic bit is_younger(input int t, input int br, input int newest);
        int p;
        p = br;
        for (int k = 0; k < `ROB_SZ; k++) begin
            if (p == newest) begin
                return 1'b0;
            end
            p = next_slot(p);
            if (p == t) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_outputs();
        bit exp_retire;
        exp_retire = (rob_count != 0) && rob_done[rob_head];
        check("alloc_tag", alloc_tag, rob_tail);
        check("rob_full", rob_full, rob_count == `ROB_SZ);
        check("retire_valid", retire_valid, exp_retire);
        if (exp_retire) begin
            check("retire_tag", retire_tag, rob_head);
            check("retire_dest", retire_dest, rob_dest[rob_head]);
        end
        check("rs1_tag", rs1_tag, rs1_valid ? map_tag[rs1_idx] : 0);
        check("rs1_ready", rs1_ready, rs1_valid ? map_tplus[rs1_idx] : 0);
        check("rs2_tag", rs2_tag, rs2_valid ? map_tag[rs2_idx] : 0);
        check("rs2_ready", rs2_ready, rs2_valid ? map_tplus[rs2_idx] : 0);
    endtask

    // one clock edge of the model, from the inputs held over the edge
    task automatic update_model();
        bit alloc;
        bit retire;
        int newest;
        int kept;
        int p;
        alloc = dispatch_valid && (rob_count != `ROB_SZ) && !branch_valid;
        retire = (rob_count != 0) && rob_done[rob_head];
        newest = (rob_tail == 1) ? `ROB_SZ : rob_tail - 1;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            if (branch_valid && is_younger(map_tag[i], branch_tag, newest)) begin
                map_tag[i] = 0;
                map_tplus[i] = 1'b0;
            end else if (alloc && has_dest && i == dest_reg && i != `ZERO_REG) begin
                map_tag[i] = rob_tail;
                map_tplus[i] = 1'b0;
            end else if (retire && map_tag[i] == rob_head) begin
                map_tag[i] = 0;
                map_tplus[i] = 1'b0;
            end else if (cdb_valid && map_tag[i] != 0 && map_tag[i] == cdb_tag) begin
                map_tplus[i] = 1'b1;
            end
        end
        // rob slots, lowest priority applied first
        if (cdb_valid && cdb_tag != 0 && rob_busy[cdb_tag]) begin
            rob_done[cdb_tag] = 1'b1;
        end
        if (alloc) begin
            rob_busy[rob_tail] = 1'b1;
            rob_done[rob_tail] = 1'b0;
            rob_dest[rob_tail] = dest_reg;
        end
        if (retire) begin
            rob_busy[rob_head] = 1'b0;
            rob_done[rob_head] = 1'b0;
        end
        if (branch_valid) begin
            for (int k = 1; k <= `ROB_SZ; k++) begin
                if (is_younger(k, branch_tag, newest)) begin
                    rob_busy[k] = 1'b0;
                    rob_done[k] = 1'b0;
                end
            end
            kept = 1;
            p = rob_head;
            while (p != branch_tag && kept <= `ROB_SZ) begin
                p = next_slot(p);
                kept++;
            end
            rob_count = kept - retire;
            rob_tail = next_slot(branch_tag);
        end else begin
            rob_count = rob_count + alloc - retire;
            if (alloc) begin
                rob_tail = next_slot(rob_tail);
            end
        end
        if (retire) begin
            rob_head = next_slot(rob_head);
        end
    endtask

    // inputs are set at a falling edge, strobes drop at the next one
    task automatic step();
        #2;
        check_outputs();
        @(posedge clock);
        update_model();
        @(negedge clock);
        dispatch_valid = 1'b0;
        has_dest = 1'b0;
        cdb_valid = 1'b0;
        branch_valid = 1'b0;
    endtask

    task automatic dispatch(input int dest, input bit with_dest);
        dispatch_valid = 1'b1;
        has_dest = with_dest;
        dest_reg = arch_reg_t'(dest);
    endtask

    task automatic read_regs(input int a, input int b);
        rs1_valid = 1'b1;
        rs2_valid = 1'b1;
        rs1_idx = arch_reg_t'(a);
        rs2_idx = arch_reg_t'(b);
    endtask

    // complete all in-flight entries newest first, then let them retire
    task automatic drain();
        int tags[$];
        int p;
        p = rob_head;
        for (int k = 0; k < rob_count; k++) begin
            tags.push_front(p);
            p = next_slot(p);
        end
        foreach (tags[k]) begin
            if (!rob_done[tags[k]]) begin
                cdb_valid = 1'b1;
                cdb_tag = rob_tag_t'(tags[k]);
                step();
            end
        end
        for (int k = 0; k < 2 * `ROB_SZ && rob_count != 0; k++) begin
            step();
        end
        if (rob_count != 0) begin
            error_count++;
            $display("ROB still holds %0d entries after draining", rob_count);
            $display("FAIL: see errors above");
            $fatal(1, "drain failed");
        end
    endtask

    task automatic after_reset_reads();
        for (int i = 0; i < `ARCH_REGS; i++) begin
            read_regs(i, `ARCH_REGS - 1 - i);
            step();
        end
        // x0 takes a slot but stays unmapped
        dispatch(`ZERO_REG, 1'b1);
        read_regs(`ZERO_REG, 1);
        step();
        // no destination, takes a slot and maps nothing
        dispatch(7, 1'b0);
        read_regs(`ZERO_REG, 7);
        step();
        read_regs(7, 0);
        step();
    endtask

    task automatic dependent_dispatch();
        dispatch(5, 1'b1);
        read_regs(5, 6);
        step();
        dispatch(6, 1'b1);
        read_regs(5, 0);
        step();
        dispatch(5, 1'b1);
        read_regs(5, 6);
        step();
        read_regs(5, 6);
        step();
    endtask

    task automatic cdb_sets_ready();
        cdb_valid = 1'b1;
        cdb_tag = rob_tag_t'(map_tag[5]);
        read_regs(5, 6);
        step();
        read_regs(5, 6);
        step();
        // invalid sources hide a mapped, ready register
        rs1_valid = 1'b0;
        rs2_valid = 1'b0;
        step();
    endtask

    task automatic out_of_order_retire();
        read_regs(5, 6);
        drain();
        step();
    endtask

    task automatic branch_squash();
        int br;
        // second of six writers, younger ones wrap past the last slot
        br = next_slot(rob_tail);
        for (int i = 1; i <= 6; i++) begin
            dispatch(i, 1'b1);
            step();
        end
        branch_valid = 1'b1;
        branch_tag = rob_tag_t'(br);
        read_regs(1, 6);
        step();
        check("alloc_tag after squash", alloc_tag, next_slot(br));
        for (int i = 1; i <= 6; i += 2) begin
            read_regs(i, i + 1);
            step();
        end
        dispatch(9, 1'b1);
        read_regs(1, 2);
        step();
        read_regs(9, 2);
        step();
        drain();
    endtask

    task automatic full_rob_stall();
        for (int i = 0; i < `ROB_SZ; i++) begin
            dispatch(10 + i, 1'b1);
            step();
        end
        check("rob_full when filled", rob_full, 1'b1);
        // dropped, x20 must stay unmapped
        dispatch(20, 1'b1);
        read_regs(20, 10);
        step();
        read_regs(20, 10);
        step();
        cdb_valid = 1'b1;
        cdb_tag = rob_tag_t'(rob_head);
        step();
        step();
        dispatch(20, 1'b1);
        read_regs(20, 10);
        step();
        read_regs(20, 11);
        step();
        drain();
    endtask

    initial begin
        reset = 1'b1;
        dispatch_valid = 1'b0;
        has_dest = 1'b0;
        dest_reg = '0;
        rs1_idx = '0;
        rs1_valid = 1'b0;
        rs2_idx = '0;
        rs2_valid = 1'b0;
        cdb_valid = 1'b0;
        cdb_tag = '0;
        branch_valid = 1'b0;
        branch_tag = '0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            map_tag[i] = 0;
            map_tplus[i] = 1'b0;
        end
        for (int k = 1; k <= `ROB_SZ; k++) begin
            rob_busy[k] = 1'b0;
            rob_done[k] = 1'b0;
            rob_dest[k] = 0;
        end
        rob_head = 1;
        rob_tail = 1;
        rob_count = 0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        after_reset_reads();
        dependent_dispatch();
        cdb_sets_ready();
        out_of_order_retire();
        branch_squash();
        full_rob_stall();

        if (error_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+verilog
verilog/rename_pkg.sv
verilog/map_table.sv
verilog/reorder_buffer.sv
verilog/rename_core.sv
sim/rename_asserts.sv
sim/rename_tb.sv

//--- Makefile
TOP = rename_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
